// File: rtl/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and constant words
    ////////////////////////////////////////////////////////////////////////////

    // Data and address width
    parameter int XLEN = 32;

    // Address of the first fetch after reset
    parameter logic [XLEN-1:0] PC_RESET = 32'h0000_0000;

    // addi x0, x0, 0
    parameter logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

    ////////////////////////////////////////////////////////////////////////////
    // Major opcodes, instruction bits 6 to 2
    ////////////////////////////////////////////////////////////////////////////

    parameter logic [4:0] OPCODE_LOAD   = 5'b00000;
    parameter logic [4:0] OPCODE_OP_IMM = 5'b00100;
    parameter logic [4:0] OPCODE_AUIPC  = 5'b00101;
    parameter logic [4:0] OPCODE_STORE  = 5'b01000;
    parameter logic [4:0] OPCODE_OP     = 5'b01100;
    parameter logic [4:0] OPCODE_LUI    = 5'b01101;
    parameter logic [4:0] OPCODE_BRANCH = 5'b11000;
    parameter logic [4:0] OPCODE_JALR   = 5'b11001;
    parameter logic [4:0] OPCODE_JAL    = 5'b11011;
    parameter logic [4:0] OPCODE_SYSTEM = 5'b11100;

    // Fetch exceptions, misaligned uses the privileged spec cause value
    typedef enum logic [3:0] {
        EXC_CODE_INSTR_MISALIGN = 4'd0,
        EXC_CODE_NO_EXCEPTION   = 4'd15
    } exc_code_e;

    // Coarse class handed to decode
    typedef enum logic [2:0] {
        CLASS_ALU    = 3'd0,
        CLASS_LOAD   = 3'd1,
        CLASS_STORE  = 3'd2,
        CLASS_BRANCH = 3'd3,
        CLASS_JAL    = 3'd4,
        CLASS_JALR   = 3'd5,
        CLASS_SYSTEM = 3'd6,
        CLASS_OTHER  = 3'd7
    } instr_class_e;

endpackage

// File: rtl/imem_rom.sv
`timescale 1ns/1ns

module imem_rom #(
    parameter int DEPTH       = 64,
    parameter int WAIT_STATES = 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load_en_i,
    input  logic [$clog2(DEPTH)-1:0]      load_addr_i,
    input  logic [fetch_pkg::XLEN-1:0]    load_data_i,
    input  logic                          req_i,
    input  logic [fetch_pkg::XLEN-1:0]    addr_i,
    output logic                          ack_o,
    output logic [fetch_pkg::XLEN-1:0]    rdata_o
);

    // Wide enough to hold WAIT_STATES, even when it is zero
    localparam int CW = $clog2(WAIT_STATES + 2);

    logic [fetch_pkg::XLEN-1:0] mem [DEPTH];
    logic [fetch_pkg::XLEN-3:0] word_idx;
    logic                       same_req;
    logic [CW-1:0]              elapsed;
    logic [CW-1:0]              cnt_q;
    logic                       req_q;
    logic [fetch_pkg::XLEN-1:0] addr_q;

    // Program load port
    always_ff @(posedge clk) begin
        if (load_en_i) begin
            mem[load_addr_i] <= load_data_i;
        end
    end

    // Word index, anything past the array reads as a NOP
    assign word_idx = addr_i[fetch_pkg::XLEN-1:2];
    assign rdata_o  = (word_idx < DEPTH) ? mem[word_idx[$clog2(DEPTH)-1:0]]
                                         : fetch_pkg::INSTR_NOP;

    // Same request as last cycle, still waiting
    assign same_req = req_q && (addr_q == addr_i);
    assign elapsed  = same_req ? cnt_q : '0;
    assign ack_o    = req_i && (elapsed == CW'(WAIT_STATES));

    // Wait counter, restarts on a dropped req, a new address or an ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
            cnt_q <= '0;
        end else begin
            req_q <= req_i && !ack_o;
            cnt_q <= elapsed + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= addr_i;
    end

    // Requester must not move the address before ack
    a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
        (req_i && !ack_o) |=> (!req_i || $stable(addr_i)))
        else $error("imem_rom: address changed while request pending");

endmodule

// File: rtl/fetch.sv
`timescale 1ns/1ns

module fetch (
    input  logic                          clk,
    input  logic                          rst_n,

    // Hazard and redirect inputs
    input  logic                          stall_i,
    input  logic                          exe_redirect_i,
    input  logic [fetch_pkg::XLEN-1:0]    exe_pc_i,
    input  logic                          csr_redirect_i,
    input  logic [fetch_pkg::XLEN-1:0]    csr_pc_i,
    input  logic                          irq_i,

    // Instruction memory
    output logic                          mem_req_o,
    output logic [fetch_pkg::XLEN-1:0]    mem_addr_o,
    input  logic                          mem_ack_i,
    input  logic [fetch_pkg::XLEN-1:0]    mem_rdata_i,

    // To predecode
    output logic                          if_valid_o,
    output logic [fetch_pkg::XLEN-1:0]    if_instr_o,
    output logic [fetch_pkg::XLEN-1:0]    if_pc_o,
    output logic [fetch_pkg::XLEN-1:0]    if_pc_next_o,
    output logic                          if_exc_req_o,
    output fetch_pkg::exc_code_e          if_exc_code_o,
    output logic                          if_irq_o
);

    logic [fetch_pkg::XLEN-1:0] pc_q;
    logic [fetch_pkg::XLEN-1:0] pc_next;
    logic [fetch_pkg::XLEN-1:0] pc_plus_4;
    logic [fetch_pkg::XLEN-1:0] jal_imm;
    logic                       redirect;
    logic                       misaligned;
    logic                       fetch_ok;
    logic                       is_jal;
    logic                       exc_emit;
    logic                       irq_emit;
    logic                       exc_hold_q;
    logic                       irq_q;
    logic                       irq_sent_q;

    ////////////////////////////////////////////////////////////////////////////
    // Request side
    ////////////////////////////////////////////////////////////////////////////

    assign redirect   = csr_redirect_i || exe_redirect_i;
    assign misaligned = pc_q[1:0] != 2'b00;

    // No request on a redirect, a bad PC or a pending interrupt
    assign mem_req_o  = !redirect && !misaligned && !irq_q;
    assign mem_addr_o = pc_q;

    // Word accepted, stalled acks are dropped and refetched
    assign fetch_ok = mem_ack_i && mem_req_o && !stall_i;

    // J-type immediate, sign extended
    assign jal_imm = {{12{mem_rdata_i[31]}}, mem_rdata_i[19:12], mem_rdata_i[20],
                      mem_rdata_i[30:21], 1'b0};
    assign is_jal  = fetch_ok && (mem_rdata_i[6:2] == fetch_pkg::OPCODE_JAL);

    assign pc_plus_4 = pc_q + 32'd4;

    ////////////////////////////////////////////////////////////////////////////
    // Next PC, csr first then exe, hold, JAL, sequential
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (csr_redirect_i) begin
            pc_next = csr_pc_i;
        end else if (exe_redirect_i) begin
            pc_next = exe_pc_i;
        end else if (stall_i || !fetch_ok) begin
            // Waiting on ack, stalled, or parked on exc / irq
            pc_next = pc_q;
        end else if (is_jal) begin
            pc_next = pc_q + jal_imm;
        end else begin
            pc_next = pc_plus_4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= fetch_pkg::PC_RESET;
        end else begin
            pc_q <= pc_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Exception and interrupt tracking
    ////////////////////////////////////////////////////////////////////////////

    // One marker item each, then park
    assign irq_emit = irq_q && !irq_sent_q && !stall_i && !redirect;
    assign exc_emit = misaligned && !irq_q && !exc_hold_q && !stall_i && !redirect;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exc_hold_q <= 1'b0;
            irq_q      <= 1'b0;
            irq_sent_q <= 1'b0;
        end else begin
            // Any redirect releases the misalign park
            if (redirect) begin
                exc_hold_q <= 1'b0;
            end else if (exc_emit) begin
                exc_hold_q <= 1'b1;
            end
            // Only the CSR unit retires an interrupt
            if (csr_redirect_i) begin
                irq_q      <= 1'b0;
                irq_sent_q <= 1'b0;
            end else begin
                if (irq_i) begin
                    irq_q <= 1'b1;
                end
                if (irq_emit) begin
                    irq_sent_q <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs to predecode
    ////////////////////////////////////////////////////////////////////////////

    assign if_valid_o    = fetch_ok || exc_emit || irq_emit;
    assign if_instr_o    = fetch_ok ? mem_rdata_i : fetch_pkg::INSTR_NOP;
    assign if_pc_o       = pc_q;
    // JAL reports its link address
    assign if_pc_next_o  = is_jal ? pc_plus_4 : pc_next;
    assign if_exc_req_o  = misaligned && !irq_q;
    assign if_exc_code_o = if_exc_req_o ? fetch_pkg::EXC_CODE_INSTR_MISALIGN
                                        : fetch_pkg::EXC_CODE_NO_EXCEPTION;
    assign if_irq_o      = irq_q;

    // Execute and CSR never steer fetch in the same cycle
    a_one_redirect : assert property (@(posedge clk) disable iff (!rst_n)
        !(exe_redirect_i && csr_redirect_i))
        else $error("fetch: exe and csr redirect together");

endmodule

// File: rtl/instr_predecode.sv
`timescale 1ns/1ns

module instr_predecode #(
    parameter int WAIT_STATES = 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          if_valid_i,
    input  logic [fetch_pkg::XLEN-1:0]    if_instr_i,
    input  logic [fetch_pkg::XLEN-1:0]    if_pc_i,
    input  logic [fetch_pkg::XLEN-1:0]    if_pc_next_i,
    input  logic                          if_exc_req_i,
    input  fetch_pkg::exc_code_e          if_exc_code_i,
    input  logic                          if_irq_i,
    output logic                          id_valid_o,
    output logic [fetch_pkg::XLEN-1:0]    id_instr_o,
    output logic [fetch_pkg::XLEN-1:0]    id_pc_o,
    output logic [fetch_pkg::XLEN-1:0]    id_pc_next_o,
    output fetch_pkg::instr_class_e       id_class_o,
    output logic                          id_exc_req_o,
    output fetch_pkg::exc_code_e          id_exc_code_o,
    output logic                          id_irq_o
);

    fetch_pkg::instr_class_e cls;

    // Major opcode to class, marker items never look like real work
    always_comb begin
        case (if_instr_i[6:2])
            fetch_pkg::OPCODE_OP,
            fetch_pkg::OPCODE_OP_IMM,
            fetch_pkg::OPCODE_LUI,
            fetch_pkg::OPCODE_AUIPC:  cls = fetch_pkg::CLASS_ALU;
            fetch_pkg::OPCODE_LOAD:   cls = fetch_pkg::CLASS_LOAD;
            fetch_pkg::OPCODE_STORE:  cls = fetch_pkg::CLASS_STORE;
            fetch_pkg::OPCODE_BRANCH: cls = fetch_pkg::CLASS_BRANCH;
            fetch_pkg::OPCODE_JAL:    cls = fetch_pkg::CLASS_JAL;
            fetch_pkg::OPCODE_JALR:   cls = fetch_pkg::CLASS_JALR;
            fetch_pkg::OPCODE_SYSTEM: cls = fetch_pkg::CLASS_SYSTEM;
            default:                  cls = fetch_pkg::CLASS_OTHER;
        endcase
        if (if_exc_req_i || if_irq_i) begin
            cls = fetch_pkg::CLASS_OTHER;
        end
    end

    // Valid strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid_o <= 1'b0;
        end else begin
            id_valid_o <= if_valid_i;
        end
    end

    // Payload, loaded only with a new item
    always_ff @(posedge clk) begin
        if (if_valid_i) begin
            id_instr_o    <= if_instr_i;
            id_pc_o       <= if_pc_i;
            id_pc_next_o  <= if_pc_next_i;
            id_class_o    <= cls;
            id_exc_req_o  <= if_exc_req_i;
            id_exc_code_o <= if_exc_code_i;
            id_irq_o      <= if_irq_i;
        end
    end

    // Memory items need at least one wait cycle between them
    a_mem_gap : assert property (@(posedge clk) disable iff (!rst_n)
        (WAIT_STATES != 0 && id_valid_o && !id_exc_req_o && !id_irq_o)
        |=> !(id_valid_o && !id_exc_req_o && !id_irq_o))
        else $error("instr_predecode: back to back memory items");

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
    parameter int ROM_DEPTH   = 64,
    parameter int WAIT_STATES = 1
) (
    input  logic                          clk,
    input  logic                          rst_n,

    // ROM program load
    input  logic                          load_en_i,
    input  logic [$clog2(ROM_DEPTH)-1:0]  load_addr_i,
    input  logic [fetch_pkg::XLEN-1:0]    load_data_i,

    // Pipeline control
    input  logic                          stall_i,
    input  logic                          exe_redirect_i,
    input  logic [fetch_pkg::XLEN-1:0]    exe_pc_i,
    input  logic                          csr_redirect_i,
    input  logic [fetch_pkg::XLEN-1:0]    csr_pc_i,
    input  logic                          irq_i,

    // Decode side
    output logic                          id_valid_o,
    output logic [fetch_pkg::XLEN-1:0]    id_instr_o,
    output logic [fetch_pkg::XLEN-1:0]    id_pc_o,
    output logic [fetch_pkg::XLEN-1:0]    id_pc_next_o,
    output fetch_pkg::instr_class_e       id_class_o,
    output logic                          id_exc_req_o,
    output fetch_pkg::exc_code_e          id_exc_code_o,
    output logic                          id_irq_o
);

    // Fetch to ROM
    logic                       mem_req;
    logic [fetch_pkg::XLEN-1:0] mem_addr;
    logic                       mem_ack;
    logic [fetch_pkg::XLEN-1:0] mem_rdata;

    // Fetch to predecode
    logic                       if_valid;
    logic [fetch_pkg::XLEN-1:0] if_instr;
    logic [fetch_pkg::XLEN-1:0] if_pc;
    logic [fetch_pkg::XLEN-1:0] if_pc_next;
    logic                       if_exc_req;
    fetch_pkg::exc_code_e       if_exc_code;
    logic                       if_irq;

    imem_rom #(
        .DEPTH       (ROM_DEPTH),
        .WAIT_STATES (WAIT_STATES)
    ) u_imem_rom (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_en_i   (load_en_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .req_i       (mem_req),
        .addr_i      (mem_addr),
        .ack_o       (mem_ack),
        .rdata_o     (mem_rdata)
    );

    fetch u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_i        (stall_i),
        .exe_redirect_i (exe_redirect_i),
        .exe_pc_i       (exe_pc_i),
        .csr_redirect_i (csr_redirect_i),
        .csr_pc_i       (csr_pc_i),
        .irq_i          (irq_i),
        .mem_req_o      (mem_req),
        .mem_addr_o     (mem_addr),
        .mem_ack_i      (mem_ack),
        .mem_rdata_i    (mem_rdata),
        .if_valid_o     (if_valid),
        .if_instr_o     (if_instr),
        .if_pc_o        (if_pc),
        .if_pc_next_o   (if_pc_next),
        .if_exc_req_o   (if_exc_req),
        .if_exc_code_o  (if_exc_code),
        .if_irq_o       (if_irq)
    );

    instr_predecode #(
        .WAIT_STATES (WAIT_STATES)
    ) u_instr_predecode (
        .clk           (clk),
        .rst_n         (rst_n),
        .if_valid_i    (if_valid),
        .if_instr_i    (if_instr),
        .if_pc_i       (if_pc),
        .if_pc_next_i  (if_pc_next),
        .if_exc_req_i  (if_exc_req),
        .if_exc_code_i (if_exc_code),
        .if_irq_i      (if_irq),
        .id_valid_o    (id_valid_o),
        .id_instr_o    (id_instr_o),
        .id_pc_o       (id_pc_o),
        .id_pc_next_o  (id_pc_next_o),
        .id_class_o    (id_class_o),
        .id_exc_req_o  (id_exc_req_o),
        .id_exc_code_o (id_exc_code_o),
        .id_irq_o      (id_irq_o)
    );

endmodule

// File: tb/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

    localparam int ROM_DEPTH    = 64;
    localparam int AW           = $clog2(ROM_DEPTH);
    localparam int RESET_CYCLES = 3;
    localparam int DRIVE_DELAY  = 2;
    localparam int MAX_CYCLES   = 120;
    localparam int WAIT_LIMIT   = 24;
    localparam int QUIET_CYCLES = 20;
    localparam int MAX_ROWS     = 32;

    // Item kinds in the expected table
    localparam int KIND_MEM = 0;
    localparam int KIND_EXC = 1;
    localparam int KIND_IRQ = 2;

    // Program words, all other ROM words hold the addi fill pattern
    localparam int N_PROG = 8;
    localparam int PROG_IDX [N_PROG] = '{2, 3, 4, 5, 9, 10, 11, 12};
    localparam logic [31:0] PROG_WORD [N_PROG] = '{
        32'h0000_A103,  // lw   x2, 0(x1)
        32'h0020_A223,  // sw   x2, 4(x1)
        32'h0000_0463,  // beq  x0, x0, 8
        32'h0100_00EF,  // jal  x1, +16
        32'h0000_8067,  // jalr x0, 0(x1)
        32'h0000_0073,  // ecall
        32'h1234_51B7,  // lui  x3, 0x12345
        32'h0000_000F   // fence
    };

    logic                          clk;
    logic                          rst_n;
    logic                          load_en;
    logic [AW-1:0]                 load_addr;
    logic [31:0]                   load_data;
    logic                          stall;
    logic                          exe_redirect;
    logic [31:0]                   exe_pc;
    logic                          csr_redirect;
    logic [31:0]                   csr_pc;
    logic                          irq;
    logic                          id_valid;
    logic [31:0]                   id_instr;
    logic [31:0]                   id_pc;
    logic [31:0]                   id_pc_next;
    fetch_pkg::instr_class_e       id_class;
    logic                          id_exc_req;
    fetch_pkg::exc_code_e          id_exc_code;
    logic                          id_irq;

    // Event table, one row per cycle that changes an input
    int          n_ev;
    int          ev_cycle  [MAX_ROWS];
    logic        ev_exe    [MAX_ROWS];
    logic [31:0] ev_exe_pc [MAX_ROWS];
    logic        ev_csr    [MAX_ROWS];
    logic [31:0] ev_csr_pc [MAX_ROWS];
    logic        ev_stall  [MAX_ROWS];
    logic        ev_irq    [MAX_ROWS];

    // Expected table, one row per id_valid pulse
    int                      n_exp;
    logic [31:0]             exp_pc    [MAX_ROWS];
    logic [31:0]             exp_instr [MAX_ROWS];
    fetch_pkg::instr_class_e exp_class [MAX_ROWS];
    logic                    exp_exc   [MAX_ROWS];
    fetch_pkg::exc_code_e    exp_code  [MAX_ROWS];
    logic                    exp_irq   [MAX_ROWS];

    int value_errors;
    int missing_errors;
    int extra_errors;

    fetch_top #(
        .ROM_DEPTH   (ROM_DEPTH),
        .WAIT_STATES (1)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .load_en_i      (load_en),
        .load_addr_i    (load_addr),
        .load_data_i    (load_data),
        .stall_i        (stall),
        .exe_redirect_i (exe_redirect),
        .exe_pc_i       (exe_pc),
        .csr_redirect_i (csr_redirect),
        .csr_pc_i       (csr_pc),
        .irq_i          (irq),
        .id_valid_o     (id_valid),
        .id_instr_o     (id_instr),
        .id_pc_o        (id_pc),
        .id_pc_next_o   (id_pc_next),
        .id_class_o     (id_class),
        .id_exc_req_o   (id_exc_req),
        .id_exc_code_o  (id_exc_code),
        .id_irq_o       (id_irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model pieces
    ////////////////////////////////////////////////////////////////////////////

    // ROM contents by word index
    function automatic logic [31:0] rom_word(input int idx);
        logic [31:0] word;
        // addi x1, x0, idx
        word = {idx[11:0], 5'd0, 3'b000, 5'd1, 7'h13};
        for (int i = 0; i < N_PROG; i++) begin
            if (PROG_IDX[i] == idx) begin
                word = PROG_WORD[i];
            end
        end
        return word;
    endfunction

    // Opcode class straight from the RV32I opcode map
    function automatic fetch_pkg::instr_class_e class_of(input logic [31:0] instr);
        case (instr[6:0])
            7'h13, 7'h33, 7'h37, 7'h17: class_of = fetch_pkg::CLASS_ALU;
            7'h03:                      class_of = fetch_pkg::CLASS_LOAD;
            7'h23:                      class_of = fetch_pkg::CLASS_STORE;
            7'h63:                      class_of = fetch_pkg::CLASS_BRANCH;
            7'h6F:                      class_of = fetch_pkg::CLASS_JAL;
            7'h67:                      class_of = fetch_pkg::CLASS_JALR;
            7'h73:                      class_of = fetch_pkg::CLASS_SYSTEM;
            default:                    class_of = fetch_pkg::CLASS_OTHER;
        endcase
    endfunction

    task automatic add_event(input int cyc, input logic exe, input logic [31:0] exe_target,
                             input logic csr, input logic [31:0] csr_target,
                             input logic stall_lvl, input logic irq_strobe);
        ev_cycle[n_ev]  = cyc;
        ev_exe[n_ev]    = exe;
        ev_exe_pc[n_ev] = exe_target;
        ev_csr[n_ev]    = csr;
        ev_csr_pc[n_ev] = csr_target;
        ev_stall[n_ev]  = stall_lvl;
        ev_irq[n_ev]    = irq_strobe;
        n_ev++;
    endtask

    task automatic add_expect(input logic [31:0] pc, input int kind);
        exp_pc[n_exp]  = pc;
        exp_exc[n_exp] = (kind == KIND_EXC);
        exp_irq[n_exp] = (kind == KIND_IRQ);
        exp_code[n_exp] = fetch_pkg::EXC_CODE_NO_EXCEPTION;
        if (kind == KIND_MEM) begin
            exp_instr[n_exp] = rom_word(int'(pc >> 2));
            exp_class[n_exp] = class_of(exp_instr[n_exp]);
        end else begin
            // Marker items carry a NOP and never look like real work
            exp_instr[n_exp] = fetch_pkg::INSTR_NOP;
            exp_class[n_exp] = fetch_pkg::CLASS_OTHER;
        end
        if (kind == KIND_EXC) begin
            exp_code[n_exp] = fetch_pkg::EXC_CODE_INSTR_MISALIGN;
        end
        n_exp++;
    endtask

    // Sequential memory items, pc rising by 4
    task automatic add_run(input logic [31:0] start_pc, input int count);
        for (int i = 0; i < count; i++) begin
            add_expect(start_pc + 32'(4 * i), KIND_MEM);
        end
    endtask

    task automatic build_tables();
        n_ev  = 0;
        n_exp = 0;
        //        cycle exe   exe_pc       csr   csr_pc       stall irq
        add_event(25,   1'b1, 32'h0000_0040, 1'b0, 32'h0,      1'b0, 1'b0);
        add_event(31,   1'b0, 32'h0,       1'b1, 32'h0000_0060, 1'b0, 1'b0);
        add_event(38,   1'b0, 32'h0,       1'b0, 32'h0,        1'b1, 1'b0);
        add_event(43,   1'b0, 32'h0,       1'b0, 32'h0,        1'b0, 1'b0);
        add_event(51,   1'b1, 32'h0000_0082, 1'b0, 32'h0,      1'b0, 1'b0);
        add_event(60,   1'b1, 32'h0000_0090, 1'b0, 32'h0,      1'b0, 1'b0);
        add_event(65,   1'b0, 32'h0,       1'b0, 32'h0,        1'b0, 1'b1);
        add_event(75,   1'b0, 32'h0,       1'b1, 32'h0000_00A0, 1'b0, 1'b0);
        add_event(81,   1'b1, 32'h0000_00AE, 1'b0, 32'h0,      1'b0, 1'b0);

        // Straight line up to the JAL at 0x14, which lands on 0x24
        add_run(32'h0000_0000, 6);
        add_run(32'h0000_0024, 6);
        // 0x3C in flight at the exe redirect, dropped
        add_run(32'h0000_0040, 2);
        // 0x48 in flight at the csr redirect, dropped
        add_run(32'h0000_0060, 3);
        // Stall window, then no gap and no repeat
        add_run(32'h0000_006C, 4);
        add_expect(32'h0000_0082, KIND_EXC);
        add_run(32'h0000_0090, 2);
        add_expect(32'h0000_0098, KIND_IRQ);
        add_run(32'h0000_00A0, 2);
        // 0xA8 dropped, parked on the misaligned target to the end
        add_expect(32'h0000_00AE, KIND_EXC);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_events();
        int ev;
        ev = 0;
        for (int cyc = 0; cyc < MAX_CYCLES; cyc++) begin
            // Strobes last one cycle, stall is a level
            exe_redirect = 1'b0;
            csr_redirect = 1'b0;
            irq          = 1'b0;
            if (ev < n_ev && ev_cycle[ev] == cyc) begin
                exe_redirect = ev_exe[ev];
                exe_pc       = ev_exe_pc[ev];
                csr_redirect = ev_csr[ev];
                csr_pc       = ev_csr_pc[ev];
                stall        = ev_stall[ev];
                irq          = ev_irq[ev];
                ev++;
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic compare_value(input int item, input string name,
                                 input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s = %h, expected %h (item %0d)", name, got, expected, item);
            value_errors++;
        end
    endtask

    task automatic check_item(input int item);
        compare_value(item, "id_pc", id_pc, exp_pc[item]);
        compare_value(item, "id_instr", id_instr, exp_instr[item]);
        compare_value(item, "id_class", 32'(id_class), 32'(exp_class[item]));
        compare_value(item, "id_exc_req", 32'(id_exc_req), 32'(exp_exc[item]));
        compare_value(item, "id_exc_code", 32'(id_exc_code), 32'(exp_code[item]));
        compare_value(item, "id_irq", 32'(id_irq), 32'(exp_irq[item]));
        // Memory items link to pc + 4, JAL included
        if (!exp_exc[item] && !exp_irq[item]) begin
            compare_value(item, "id_pc_next", id_pc_next, exp_pc[item] + 32'd4);
        end else begin
            // Marker items leave fetch parked on their own pc
            compare_value(item, "id_pc_next", id_pc_next, exp_pc[item]);
        end
    endtask

    task automatic monitor_items();
        int   item;
        int   waited;
        logic timed_out;
        item      = 0;
        timed_out = 1'b0;
        while (item < n_exp && !timed_out) begin
            // Sample at the falling edge, away from register updates
            waited = 0;
            @(negedge clk);
            while (!id_valid && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!id_valid) begin
                $display("Timed out waiting for item %0d at pc %h", item, exp_pc[item]);
                missing_errors++;
                timed_out = 1'b1;
            end else begin
                check_item(item);
                item++;
            end
        end
        // Fetch is parked, nothing more may arrive
        if (!timed_out) begin
            for (int i = 0; i < QUIET_CYCLES; i++) begin
                @(negedge clk);
                if (id_valid) begin
                    $display("Unexpected extra item at pc %h after the last one", id_pc);
                    extra_errors++;
                end
            end
        end
    endtask

    initial begin
        int idx;
        value_errors   = 0;
        missing_errors = 0;
        extra_errors   = 0;
        rst_n          = 1'b0;
        load_en        = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        stall          = 1'b0;
        exe_redirect   = 1'b0;
        exe_pc         = '0;
        csr_redirect   = 1'b0;
        csr_pc         = '0;
        irq            = 1'b0;
        build_tables();

        // Whole ROM loaded inside the reset window
        for (idx = 0; idx < ROM_DEPTH; idx++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            load_en   = 1'b1;
            load_addr = AW'(idx);
            load_data = rom_word(idx);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        load_en = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // Cycle 0 starts here
        fork
            drive_events();
            monitor_items();
        join

        $display("Errors: value %0d, missing %0d, extra %0d",
                 value_errors, missing_errors, extra_errors);
        if (value_errors + missing_errors + extra_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
rtl/fetch_pkg.sv
rtl/imem_rom.sv
rtl/fetch.sv
rtl/instr_predecode.sv
rtl/fetch_top.sv
tb/fetch_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = fetch_tb
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
